// ==== src/bus_pkg.sv ====
/*
 * Bus-side definitions for the progress control block.
 * The address region is taken from address bits 31..30 only.
 * Control registers sit in the EBR region, selected by the top nibble.
 * Byte selects are four lanes wide, one per byte of a 32-bit word.
 */
`default_nettype none

package bus_pkg;

   // Region decode of addr[31:30]
   typedef enum logic [1:0] {
      REGION_EBR     = 2'b00, // Internal block RAM, no bus strobe
      REGION_IO      = 2'b01, // I/O devices, served by io_stb
      REGION_SRAM_LO = 2'b10, // SRAM, lower half
      REGION_SRAM_HI = 2'b11  // SRAM, upper half
   } addr_region_e;

   // Top address nibble of the control registers (0x2xxxxxxx)
   localparam logic [3:0] SYSREG_NIBBLE = 4'd2;

   // Byte select width
   localparam int SEL_W = 4;

   localparam logic [SEL_W-1:0] SEL_NONE = '0; // No lanes, reset value of sel
   localparam logic [SEL_W-1:0] SEL_ALL  = '1; // Full word, reset value of bmask

endpackage : bus_pkg

`default_nettype wire

// ==== src/ucode_pkg.sv ====
/*
 * Microcode-side definitions for the progress control block.
 * wr_sel_e names only the halfword and byte codes of the write-address
 * field. Every other four-bit code is treated as a full word store.
 */
`default_nettype none

package ucode_pkg;

   // Write-address opcode field of the microcode word
   typedef enum logic [3:0] {
      WSEL_HALF = 4'b0001, // Halfword store
      WSEL_BYTE = 4'b0010  // Byte store
   } wr_sel_e;

   // Acknowledge qualifier state
   typedef enum logic {
      ACK_NORMAL = 1'b0, // qack needs io_ack together with io_stb
      ACK_HELD   = 1'b1  // Slave holds its ack, io_stb alone qualifies
   } ack_state_e;

endpackage : ucode_pkg

`default_nettype wire

// ==== src/byte_select.sv ====
/*
 * Registered byte selects for stores, plus the active-low copy used
 * as write mask by the EBR.
 * A halfword store at offset 01 or 11 falls back to a full word.
 * Both registers load only when latch_sel is high.
 */
`default_nettype none

module byte_select (
   input  wire logic              clk,
   input  wire logic              RST_I,
   input  wire logic              latch_sel, // Load new selects
   input  wire ucode_pkg::wr_sel_e wr_sel,   // Store width from microcode
   input  wire logic [1:0]        addr_lo,   // Byte offset of the address
   output logic [3:0]             sel,
   output logic [3:0]             bmask
);

   logic [bus_pkg::SEL_W-1:0] sel_d; // Decoded lanes

   // Lane decode
   always_comb begin
      sel_d = bus_pkg::SEL_ALL; // Word store or unknown code
      case (wr_sel)
         ucode_pkg::WSEL_HALF: begin
            if (addr_lo == 2'b00)
               sel_d = 4'b0011; // Lower half
            else if (addr_lo == 2'b10)
               sel_d = 4'b1100; // Upper half
         end
         ucode_pkg::WSEL_BYTE: begin
            sel_d = 4'b0001 << addr_lo; // One lane per offset
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (RST_I) begin
         sel   <= bus_pkg::SEL_NONE;
         bmask <= bus_pkg::SEL_ALL; // Nothing masked off
      end else if (latch_sel) begin
         sel   <= sel_d;
         bmask <= ~sel_d; // EBR wants active low
      end
   end

endmodule : byte_select

`default_nettype wire

// ==== src/bus_request.sv ====
/*
 * Bus request registers: I/O strobe, SRAM strobe, write enable and
 * control-register write enable.
 * A strobe is held until its acknowledge, then falls the next cycle.
 * The sequencer must not raise req_access while a strobe is high.
 * A word store to an unaligned address gives neither strobe nor write.
 * Nothing is requested while corerunning is low.
 */
`default_nettype none

module bus_request #(
   parameter bit HAS_SRAM   = 1'b1, // SRAM strobe present
   parameter bit HAS_SYSREG = 1'b1  // Control registers present
) (
   input  wire logic        clk,
   input  wire logic        RST_I,
   input  wire logic        corerunning,
   input  wire logic        req_access, // Start an I/O or SRAM access
   input  wire logic        req_write,  // Load the write enables
   input  wire logic        keep_write, // Low clears the write enables
   input  wire logic        word_store, // Access is a 32-bit store
   input  wire logic        bus_error,
   input  wire logic        sram_ack,
   input  wire logic        qack,       // Qualified I/O acknowledge
   input  wire logic [31:0] addr,
   output logic             io_stb,
   output logic             sram_stb,
   output logic             we,
   output logic             ctrlreg_we
);

   bus_pkg::addr_region_e region;
   logic                  misaligned;
   logic                  abort;      // Reset or bus error
   logic                  io_hit;
   logic                  is_sysreg;

   assign region     = bus_pkg::addr_region_e'(addr[31:30]);
   assign misaligned = ~corerunning | (word_store & (addr[1:0] != 2'b00));
   assign abort      = RST_I | bus_error;
   assign io_hit     = req_access & (region == bus_pkg::REGION_IO) & ~misaligned;
   assign is_sysreg  = (addr[31:28] == bus_pkg::SYSREG_NIBBLE);

   // I/O strobe, held until qack
   always_ff @(posedge clk) begin
      if (abort)
         io_stb <= 1'b0;
      else
         io_stb <= io_hit | (io_stb & ~qack);
   end

   generate
      if (HAS_SRAM) begin : g_sram
         logic sram_hit;
         assign sram_hit = req_access & ~misaligned &
                           ((region == bus_pkg::REGION_SRAM_LO) |
                            (region == bus_pkg::REGION_SRAM_HI));
         always_ff @(posedge clk) begin
            if (abort)
               sram_stb <= 1'b0;
            else
               sram_stb <= sram_hit | (sram_stb & ~sram_ack); // Held until sram_ack
         end
      end else begin : g_no_sram
         assign sram_stb = 1'b0;
      end
   endgenerate

   // Write enable, any region outside the EBR
   always_ff @(posedge clk) begin
      if (abort | ~keep_write)
         we <= 1'b0;
      else if (req_write)
         we <= (region != bus_pkg::REGION_EBR) & ~misaligned;
   end

   generate
      if (HAS_SYSREG) begin : g_sysreg
         always_ff @(posedge clk) begin
            if (abort | ~keep_write)
               ctrlreg_we <= 1'b0;
            else if (req_write)
               ctrlreg_we <= is_sysreg & ~misaligned; // 0x2xxxxxxx lies in EBR space
         end
      end else begin : g_no_sysreg
         assign ctrlreg_we = 1'b0;
      end
   endgenerate

   // One access in flight at a time
   a_one_stb : assert property (@(posedge clk) disable iff (RST_I)
      !(io_stb && sram_stb));

endmodule : bus_request

`default_nettype wire

// ==== src/ack_qualifier.sv ====
/*
 * Acknowledge qualifier.
 * Copes with a point-to-point slave that holds its ack high: an ack seen
 * without a strobe moves to ACK_HELD, where io_stb alone qualifies.
 * io_ack going low returns to ACK_NORMAL.
 * qack is combinational from io_ack, sysreg_ack and io_stb.
 */
`default_nettype none

module ack_qualifier #(
   parameter bit RESPECT_HELD_ACK = 1'b1, // Use the held-ack state machine
   parameter bit HAS_SYSREG       = 1'b1  // Accept sysreg_ack
) (
   input  wire logic clk,
   input  wire logic RST_I,
   input  wire logic io_ack,
   input  wire logic sysreg_ack,
   input  wire logic io_stb,
   output logic      qack
);

   logic sys_ack; // sysreg_ack, or zero without control registers

   assign sys_ack = HAS_SYSREG ? sysreg_ack : 1'b0;

   generate
      if (RESPECT_HELD_ACK) begin : g_held
         ucode_pkg::ack_state_e state;
         ucode_pkg::ack_state_e state_d;

         // Stay or enter HELD while the ack is up and unexplained
         assign state_d = (io_ack & (~io_stb | (state == ucode_pkg::ACK_HELD))) ?
                          ucode_pkg::ACK_HELD : ucode_pkg::ACK_NORMAL;

         always_ff @(posedge clk) begin
            if (RST_I)
               state <= ucode_pkg::ACK_NORMAL;
            else
               state <= state_d;
         end

         assign qack = sys_ack | ((state == ucode_pkg::ACK_HELD) ? io_stb   // Ack is stuck high
                                                                 : (io_ack & io_stb));

         a_state_known : assert property (@(posedge clk) disable iff (RST_I)
            !$isunknown(state));
      end else begin : g_plain
         assign qack = io_ack | sys_ack; // Trust the slave
      end
   endgenerate

endmodule : ack_qualifier

`default_nettype wire

// ==== src/progress_gate.sv ====
/*
 * Combinational gating of Q sampling, microcode progress and the
 * internal EBR write.
 * Any strobe high stalls the microcode and Q until the access ends.
 * bus_error always lets the microcode move on.
 */
`default_nettype none

module progress_gate (
   input  wire logic corerunning,
   input  wire logic q_sample,     // Q sample request
   input  wire logic q_read,       // Q read request
   input  wire logic shift_repeat, // Repeat shift until done
   input  wire logic lastshift,
   input  wire logic rlastshift,   // Registered lastshift
   input  wire logic latch_sel,
   input  wire logic bus_error,
   input  wire logic io_stb,
   input  wire logic sram_stb,
   input  wire logic we,
   output logic      enaq,
   output logic      progress_ucode,
   output logic      iwe
);

   logic busy; // Bus access in flight

   assign busy = io_stb | sram_stb;

   assign enaq = (q_sample | q_read) & ~lastshift & ~busy;

   // Wait for the shifter and for the bus, unless the bus failed
   assign progress_ucode = ((~shift_repeat | lastshift | rlastshift) & ~busy) | bus_error;

   // No EBR write while setting up selects, writing the bus or holding a zero shift
   assign iwe = corerunning & ~(latch_sel | we | rlastshift);

endmodule : progress_gate

`default_nettype wire

// ==== src/progress_ctrl.sv ====
/*
 * Bus and progress control of the serial core.
 * Strobes and write enables are plain levels, held until acknowledged.
 * Only one bus access may be in flight; the microcode stalls meanwhile.
 * Control registers are decoded at 0x2xxxxxxx when HAS_SYSREG is set.
 */
`default_nettype none

module progress_ctrl #(
   parameter bit HAS_SRAM         = 1'b1,
   parameter bit HAS_SYSREG       = 1'b1,
   parameter bit RESPECT_HELD_ACK = 1'b1
) (
   input  wire logic              clk,
   input  wire logic              RST_I,
   input  wire logic              corerunning,
   input  wire logic              io_ack,
   input  wire logic              sysreg_ack,
   input  wire logic              sram_ack,
   input  wire logic              latch_sel,
   input  wire logic              req_access,
   input  wire logic              req_write,
   input  wire logic              keep_write,
   input  wire logic              word_store,
   input  wire logic              q_sample,
   input  wire logic              q_read,
   input  wire logic              shift_repeat,
   input  wire logic              lastshift,
   input  wire logic              rlastshift,
   input  wire logic              bus_error,
   input  wire ucode_pkg::wr_sel_e wr_sel,
   input  wire logic [31:0]       addr,
   output logic [3:0]             sel,
   output logic [3:0]             bmask,
   output logic                   io_stb,
   output logic                   sram_stb,
   output logic                   we,
   output logic                   ctrlreg_we,
   output logic                   qack,
   output logic                   enaq,
   output logic                   progress_ucode,
   output logic                   iwe
);

   byte_select u_byte_select (
      .clk       (clk),
      .RST_I     (RST_I),
      .latch_sel (latch_sel),
      .wr_sel    (wr_sel),
      .addr_lo   (addr[1:0]),
      .sel       (sel),
      .bmask     (bmask)
   );

   bus_request #(
      .HAS_SRAM   (HAS_SRAM),
      .HAS_SYSREG (HAS_SYSREG)
   ) u_bus_request (
      .clk         (clk),
      .RST_I       (RST_I),
      .corerunning (corerunning),
      .req_access  (req_access),
      .req_write   (req_write),
      .keep_write  (keep_write),
      .word_store  (word_store),
      .bus_error   (bus_error),
      .sram_ack    (sram_ack),
      .qack        (qack),
      .addr        (addr),
      .io_stb      (io_stb),
      .sram_stb    (sram_stb),
      .we          (we),
      .ctrlreg_we  (ctrlreg_we)
   );

   ack_qualifier #(
      .RESPECT_HELD_ACK (RESPECT_HELD_ACK),
      .HAS_SYSREG       (HAS_SYSREG)
   ) u_ack_qualifier (
      .clk        (clk),
      .RST_I      (RST_I),
      .io_ack     (io_ack),
      .sysreg_ack (sysreg_ack),
      .io_stb     (io_stb),
      .qack       (qack)
   );

   progress_gate u_progress_gate (
      .corerunning    (corerunning),
      .q_sample       (q_sample),
      .q_read         (q_read),
      .shift_repeat   (shift_repeat),
      .lastshift      (lastshift),
      .rlastshift     (rlastshift),
      .latch_sel      (latch_sel),
      .bus_error      (bus_error),
      .io_stb         (io_stb),
      .sram_stb       (sram_stb),
      .we             (we),
      .enaq           (enaq),
      .progress_ucode (progress_ucode),
      .iwe            (iwe)
   );

endmodule : progress_ctrl

`default_nettype wire

// ==== verification/progress_model.svh ====
/*
 * Cycle model of progress_ctrl with SRAM, control registers and the
 * held-ack qualifier all enabled.
 * Included inside the testbench module, reads its input variables by name.
 * Call step_model once per rising edge, before new inputs are driven.
 * The output predictions are valid between edges.
 */
`ifndef PROGRESS_MODEL_SVH
`define PROGRESS_MODEL_SVH

logic [3:0]            m_sel;          // Registered byte selects
logic [3:0]            m_bmask;
logic                  m_io_stb;
logic                  m_sram_stb;
logic                  m_we;
logic                  m_ctrlreg_we;
ucode_pkg::ack_state_e m_ack;          // Qualifier state
logic                  m_after_reset;  // Last edge saw RST_I

// Byte lanes of a store, by width code and address offset
function automatic logic [3:0] lanes_for(ucode_pkg::wr_sel_e code, logic [1:0] offset);
   logic [3:0] lanes;
   lanes = bus_pkg::SEL_ALL; // Word store, or a code with no meaning
   if (code == ucode_pkg::WSEL_HALF && offset == 2'b00)
      lanes = 4'b0011;
   else if (code == ucode_pkg::WSEL_HALF && offset == 2'b10)
      lanes = 4'b1100;
   else if (code == ucode_pkg::WSEL_BYTE) begin
      lanes = 4'b0000;
      lanes[offset] = 1'b1; // Single lane
   end
   return lanes;
endfunction

function automatic logic predict_qack();
   if (m_ack == ucode_pkg::ACK_HELD)
      return sysreg_ack | m_io_stb; // Ack stuck high, strobe alone counts
   return sysreg_ack | (io_ack & m_io_stb);
endfunction

function automatic logic enaq_expected();
   return (q_sample || q_read) && !lastshift && !(m_io_stb || m_sram_stb);
endfunction

function automatic logic ucode_may_progress();
   if (bus_error)
      return 1'b1;                  // Bus failure always moves on
   return (!shift_repeat || lastshift || rlastshift) && !(m_io_stb || m_sram_stb);
endfunction

function automatic logic ebr_write_allowed();
   return corerunning && !latch_sel && !m_we && !rlastshift;
endfunction

// Register update at one rising edge
task automatic step_model();
   logic                  ack_now;
   logic                  bad;
   bus_pkg::addr_region_e region;
   ack_now = predict_qack();     // Uses the state before the edge
   bad     = !corerunning || (word_store && addr[1:0] != 2'b00);
   region  = bus_pkg::addr_region_e'(addr[31:30]);
   m_after_reset = RST_I;
   if (RST_I) begin
      m_sel   = bus_pkg::SEL_NONE;
      m_bmask = bus_pkg::SEL_ALL;
      m_ack   = ucode_pkg::ACK_NORMAL;
   end else begin
      if (latch_sel) begin
         m_sel   = lanes_for(wr_sel, addr[1:0]);
         m_bmask = ~m_sel;
      end
      // Held when the ack is up with no strobe to explain it
      if (io_ack && (!m_io_stb || m_ack == ucode_pkg::ACK_HELD))
         m_ack = ucode_pkg::ACK_HELD;
      else
         m_ack = ucode_pkg::ACK_NORMAL;
   end
   if (RST_I || bus_error) begin
      m_io_stb   = 1'b0;
      m_sram_stb = 1'b0;
   end else begin
      m_io_stb   = (req_access && !bad && region == bus_pkg::REGION_IO) ||
                   (m_io_stb && !ack_now);
      m_sram_stb = (req_access && !bad && (region == bus_pkg::REGION_SRAM_LO ||
                                           region == bus_pkg::REGION_SRAM_HI)) ||
                   (m_sram_stb && !sram_ack);
   end
   if (RST_I || bus_error || !keep_write) begin
      m_we         = 1'b0;
      m_ctrlreg_we = 1'b0;
   end else if (req_write) begin
      m_we         = region != bus_pkg::REGION_EBR && !bad;
      m_ctrlreg_we = addr[31:28] == bus_pkg::SYSREG_NIBBLE && !bad;
   end
endtask

`endif

// ==== verification/progress_ctrl_tb.sv ====
/*
 * Random testbench for progress_ctrl with its default parameters.
 * Inputs change on the rising edge; outputs are compared with the
 * cycle model on the falling edge, when all of them have settled.
 * req_access is raised only while no strobe is in flight.
 * Fixed seed, so every run sees the same stimulus.
 */
`default_nettype none

module progress_ctrl_tb;

   localparam int RESET_CYCLES   = 8;
   localparam int RANDOM_CYCLES  = 2000;
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + RANDOM_CYCLES + 192; // 2200
   localparam int SEED           = 27;

   logic               clk;
   logic               RST_I;
   logic               corerunning, io_ack, sysreg_ack, sram_ack;
   logic               latch_sel, req_access, req_write, keep_write, word_store;
   logic               q_sample, q_read, shift_repeat, lastshift, rlastshift, bus_error;
   ucode_pkg::wr_sel_e wr_sel;
   logic [31:0]        addr;
   logic [3:0]         sel, bmask;
   logic               io_stb, sram_stb, we, ctrlreg_we, qack, enaq, progress_ucode, iwe;

   int   errors   = 0;
   int   checks   = 0;
   int   cycles   = 0;
   int   ack_hold = 0;    // Cycles left of a held io_ack
   logic checking = 1'b0; // Model valid after the first reset edge

   `include "progress_model.svh"

   progress_ctrl dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Run limit
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
         $display("Some tests failed");
         $finish;
      end
   end

   function automatic logic chance(int pct);
      return ($urandom % 100) < pct;
   endfunction

   task automatic expect_bit(input string name, input logic got, input logic exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("[FAIL] %0t: %s is %b, model gives %b", $time, name, got, exp);
      end
   endtask

   task automatic compare_lanes(input string name, input logic [3:0] got,
                                input logic [3:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("[FAIL] %0t: %s is %b, model gives %b", $time, name, got, exp);
      end
   endtask

   // One cycle of random inputs
   task automatic drive_random();
      logic [31:0] a;
      logic [31:0] r;
      a = $urandom;
      r = $urandom;
      if (chance(15))
         a[31:28] = bus_pkg::SYSREG_NIBBLE; // Control register space
      if (chance(50))
         a[1:0] = 2'b00;                    // Aligned half the time
      addr <= a;
      if (chance(35))
         wr_sel <= ucode_pkg::WSEL_HALF;
      else if (chance(50))
         wr_sel <= ucode_pkg::WSEL_BYTE;
      else
         wr_sel <= ucode_pkg::wr_sel_e'(r[3:0]); // Any code, mostly full word
      corerunning  <= chance(92);
      req_access   <= !m_io_stb && !m_sram_stb && chance(25); // One access at a time
      req_write    <= chance(25);
      keep_write   <= chance(90);
      word_store   <= chance(50);
      latch_sel    <= chance(20);
      sram_ack     <= chance(35);
      sysreg_ack   <= chance(5);
      q_sample     <= chance(30);
      q_read       <= chance(20);
      shift_repeat <= chance(40);
      lastshift    <= chance(15);
      rlastshift   <= chance(15);
      bus_error    <= chance(1);
      RST_I        <= ($urandom % 400) == 0; // Rare reset pulse
      if (ack_hold > 0) begin
         io_ack <= 1'b1;
         ack_hold--;
      end else if (chance(2)) begin
         ack_hold = 10 + ($urandom % 30); // Slave that keeps its ack up
         io_ack <= 1'b1;
      end else
         io_ack <= m_io_stb ? chance(40) : chance(3);
   endtask

   // Compare in the middle of the cycle
   always @(negedge clk) begin
      if (checking) begin
         compare_lanes("sel", sel, m_sel);
         compare_lanes("bmask", bmask, m_bmask);
         expect_bit("io_stb", io_stb, m_io_stb);
         expect_bit("sram_stb", sram_stb, m_sram_stb);
         expect_bit("we", we, m_we);
         expect_bit("ctrlreg_we", ctrlreg_we, m_ctrlreg_we);
         expect_bit("qack", qack, predict_qack());
         expect_bit("enaq", enaq, enaq_expected());
         expect_bit("progress_ucode", progress_ucode, ucode_may_progress());
         expect_bit("iwe", iwe, ebr_write_allowed());
         if (m_after_reset) begin
            checks++;
            assert ({sel, io_stb, sram_stb, we, ctrlreg_we} === 8'h00 &&
                    bmask === bus_pkg::SEL_ALL) else begin
               errors++;
               $display("[FAIL] %0t: control outputs still active after reset", $time);
            end
         end
      end
   end

   initial begin
      void'($urandom(SEED));
      RST_I        <= 1'b1;
      corerunning  <= 1'b0;
      io_ack       <= 1'b0;
      sysreg_ack   <= 1'b0;
      sram_ack     <= 1'b0;
      latch_sel    <= 1'b0;
      req_access   <= 1'b0;
      req_write    <= 1'b0;
      keep_write   <= 1'b0;
      word_store   <= 1'b0;
      q_sample     <= 1'b0;
      q_read       <= 1'b0;
      shift_repeat <= 1'b0;
      lastshift    <= 1'b0;
      rlastshift   <= 1'b0;
      bus_error    <= 1'b0;
      wr_sel       <= ucode_pkg::WSEL_HALF;
      addr         <= '0;
      repeat (RESET_CYCLES) begin
         @(posedge clk);
         step_model();
         checking = 1'b1;
      end
      RST_I <= 1'b0;
      repeat (RANDOM_CYCLES) begin
         @(posedge clk);
         step_model();   // Model takes the edge first, then new inputs
         drive_random();
      end
      @(posedge clk);
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule : progress_ctrl_tb

`default_nettype wire

// ==== all.f ====
+incdir+verification
src/bus_pkg.sv
src/ucode_pkg.sv
src/byte_select.sv
src/bus_request.sv
src/ack_qualifier.sv
src/progress_gate.sv
src/progress_ctrl.sv
verification/progress_ctrl_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the progress_ctrl testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module progress_ctrl_tb -f all.f -o progress_ctrl_sim

out=$(./obj_dir/progress_ctrl_sim 2>&1) || true
printf '%s\n' "$out"

# Pass only when the testbench printed its pass line
printf '%s\n' "$out" | grep -qx "All tests passed"
